// File: rvc_pkg.sv
package rvc_pkg;

  // ----------------------------------------
  // instruction words
  // ----------------------------------------
  typedef logic [31:0] instr_t;

  // low half of a fetched word, the compressed encoding
  typedef logic [15:0] half_t;

  // instr[1:0], 2'b11 marks a full-width instruction
  typedef enum logic [1:0] {
    quad_0    = 2'b00,
    quad_1    = 2'b01,
    quad_2    = 2'b10,
    quad_full = 2'b11
  } quadrant_e;

  // base opcodes produced by the expansion
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_e;

  // ----------------------------------------
  // funct3 slots, instr[15:13]
  // ----------------------------------------
  typedef enum logic [2:0] {
    c0_addi4spn, c0_fld, c0_lw, c0_flw, c0_zcb, c0_fsd, c0_sw, c0_fsw
  } c0_funct3_e;

  typedef enum logic [2:0] {
    c1_addi, c1_jal, c1_li, c1_lui, c1_misc_alu, c1_j, c1_beqz, c1_bnez
  } c1_funct3_e;

  typedef enum logic [2:0] {
    c2_slli, c2_fldsp, c2_lwsp, c2_flwsp, c2_jr_mv_add, c2_fsdsp, c2_swsp, c2_fswsp
  } c2_funct3_e;

  // ----------------------------------------
  // registers
  // ----------------------------------------
  localparam logic [4:0] reg_zero = 5'd0;
  localparam logic [4:0] reg_ra   = 5'd1;
  localparam logic [4:0] reg_sp   = 5'd2;

  // rd'/rs1'/rs2' only reach x8..x15
  localparam logic [1:0] rvc_prime_prefix = 2'b01;

  // ebreak: imm 1, funct3 0, rs1 and rd zero
  localparam instr_t ebreak_instr = {
    12'h001,
    reg_zero,
    3'b000,
    reg_zero,
    opc_system
  };

endpackage

// File: rvc_expand_q0.sv
`timescale 1ns/1ps

module rvc_expand_q0 import rvc_pkg::*; (
  input  half_t  half_i,
  output instr_t instr_o,
  output logic   illegal_o
);

  c0_funct3_e funct3;
  logic [4:0] rd_p;
  logic [4:0] rs1_p;

  assign funct3 = c0_funct3_e'(half_i[15:13]);
  // rd' doubles as rs2' for c.sw
  assign rd_p   = {rvc_prime_prefix, half_i[4:2]};
  assign rs1_p  = {rvc_prime_prefix, half_i[9:7]};

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;
    unique case (funct3)
      c0_addi4spn: begin
        // addi rd', sp, nzuimm[9:2]
        instr_o = {2'b00, half_i[10:7], half_i[12:11], half_i[5], half_i[6], 2'b00,
                   reg_sp, 3'b000, rd_p, opc_op_imm};
        illegal_o = (half_i[12:5] == 8'b0);
      end
      c0_lw: begin
        // lw rd', uimm[6:2](rs1')
        instr_o = {5'b0, half_i[5], half_i[12:10], half_i[6], 2'b00,
                   rs1_p, 3'b010, rd_p, opc_load};
      end
      c0_sw: begin
        // offset split across the S-type immediate fields
        instr_o = {5'b0, half_i[5], half_i[12], rd_p, rs1_p, 3'b010,
                   half_i[11:10], half_i[6], 2'b00, opc_store};
      end
      c0_fld, c0_flw, c0_fsd, c0_fsw: begin
        // no floating point
        illegal_o = 1'b1;
      end
      c0_zcb: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// File: rvc_expand_q1.sv
`timescale 1ns/1ps

module rvc_expand_q1 import rvc_pkg::*; (
  input  half_t  half_i,
  output instr_t instr_o,
  output logic   illegal_o
);

  c1_funct3_e  funct3;
  logic [4:0]  rd;
  logic [4:0]  rd_p;
  logic [4:0]  rs2_p;
  logic [11:0] imm6_sext;
  logic [11:0] j_imm;
  logic [8:0]  b_imm;

  assign funct3    = c1_funct3_e'(half_i[15:13]);
  assign rd        = half_i[11:7];
  assign rd_p      = {rvc_prime_prefix, half_i[9:7]};
  assign rs2_p     = {rvc_prime_prefix, half_i[4:2]};
  assign imm6_sext = {{6{half_i[12]}}, half_i[12], half_i[6:2]};

  // ----------------------------------------
  // offset reassembly
  // ----------------------------------------
  // c.j / c.jal offset[11:0], bit 0 always zero
  assign j_imm = {half_i[12], half_i[8], half_i[10:9], half_i[6], half_i[7],
                  half_i[2], half_i[11], half_i[5:3], 1'b0};

  // c.beqz / c.bnez offset[8:0]
  assign b_imm = {half_i[12], half_i[6:5], half_i[2], half_i[11:10], half_i[4:3], 1'b0};

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;
    unique case (funct3)
      c1_addi: begin
        // rd of zero gives c.nop, still an addi
        instr_o = {imm6_sext, rd, 3'b000, rd, opc_op_imm};
      end
      c1_li: begin
        instr_o = {imm6_sext, reg_zero, 3'b000, rd, opc_op_imm};
      end
      c1_lui: begin
        if (rd == reg_sp) begin
          // c.addi16sp, nzimm[9:4]
          instr_o = {{3{half_i[12]}}, half_i[4:3], half_i[5], half_i[2], half_i[6], 4'b0,
                     reg_sp, 3'b000, reg_sp, opc_op_imm};
        end else begin
          instr_o = {{15{half_i[12]}}, half_i[6:2], rd, opc_lui};
        end
        illegal_o = ({half_i[12], half_i[6:2]} == 6'b0);
      end
      c1_misc_alu: begin
        unique case (half_i[11:10])
          2'b00, 2'b01: begin
            // srli / srai, bit 10 selects arithmetic
            instr_o = {1'b0, half_i[10], 4'b0, half_i[12], half_i[6:2],
                       rd_p, 3'b101, rd_p, opc_op_imm};
          end
          2'b10: begin
            instr_o = {imm6_sext, rd_p, 3'b111, rd_p, opc_op_imm};
          end
          2'b11: begin
            unique case ({half_i[12], half_i[6:5]})
              3'b000: instr_o = {7'b0100000, rs2_p, rd_p, 3'b000, rd_p, opc_op};
              3'b001: instr_o = {7'b0000000, rs2_p, rd_p, 3'b100, rd_p, opc_op};
              3'b010: instr_o = {7'b0000000, rs2_p, rd_p, 3'b110, rd_p, opc_op};
              3'b011: instr_o = {7'b0000000, rs2_p, rd_p, 3'b111, rd_p, opc_op};
              default: begin
                // subw, addw and the zcb mul/ext slots
                illegal_o = 1'b1;
              end
            endcase
          end
        endcase
      end

      // ----------------------------------------
      // control transfer
      // ----------------------------------------
      c1_jal: begin
        instr_o = {j_imm[11], j_imm[10:1], j_imm[11], {8{j_imm[11]}}, reg_ra, opc_jal};
      end
      c1_j: begin
        instr_o = {j_imm[11], j_imm[10:1], j_imm[11], {8{j_imm[11]}}, reg_zero, opc_jal};
      end
      c1_beqz, c1_bnez: begin
        // funct3 bit 0 comes straight from instr[13]
        instr_o = {{3{b_imm[8]}}, b_imm[8:5], reg_zero, rd_p, 2'b00, half_i[13],
                   b_imm[4:1], b_imm[8], opc_branch};
      end
    endcase
  end

endmodule

// File: rvc_expand_q2.sv
`timescale 1ns/1ps

module rvc_expand_q2 import rvc_pkg::*; (
  input  half_t  half_i,
  output instr_t instr_o,
  output logic   illegal_o
);

  c2_funct3_e funct3;
  logic [4:0] rd;
  logic [4:0] rs2;

  assign funct3 = c2_funct3_e'(half_i[15:13]);
  assign rd     = half_i[11:7];
  assign rs2    = half_i[6:2];

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;
    unique case (funct3)
      c2_slli: begin
        instr_o = {6'b0, half_i[12], half_i[6:2], rd, 3'b001, rd, opc_op_imm};
      end
      c2_lwsp: begin
        // uimm[7:2] off sp
        instr_o = {4'b0, half_i[3:2], half_i[12], half_i[6:4], 2'b00,
                   reg_sp, 3'b010, rd, opc_load};
        illegal_o = (rd == reg_zero);
      end
      c2_swsp: begin
        instr_o = {4'b0, half_i[8:7], half_i[12], rs2, reg_sp, 3'b010,
                   half_i[11:9], 2'b00, opc_store};
      end

      // ----------------------------------------
      // jr / mv / ebreak / jalr / add
      // ----------------------------------------
      c2_jr_mv_add: begin
        if (!half_i[12]) begin
          if (rs2 == reg_zero) begin
            // c.jr
            instr_o   = {12'b0, rd, 3'b000, reg_zero, opc_jalr};
            illegal_o = (rd == reg_zero);
          end else begin
            // c.mv
            instr_o = {7'b0, rs2, reg_zero, 3'b000, rd, opc_op};
          end
        end else begin
          if (rs2 != reg_zero) begin
            // c.add
            instr_o = {7'b0, rs2, rd, 3'b000, rd, opc_op};
          end else if (rd == reg_zero) begin
            instr_o = ebreak_instr;
          end else begin
            // c.jalr links to ra
            instr_o = {12'b0, rd, 3'b000, reg_ra, opc_jalr};
          end
        end
      end
      c2_fldsp, c2_flwsp, c2_fsdsp, c2_fswsp: begin
        // no floating point
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// File: rvc_decode_reg.sv
`timescale 1ns/1ps

module rvc_decode_reg import rvc_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   valid_i,
  input  instr_t instr_i,
  input  instr_t q0_instr_i,
  input  instr_t q1_instr_i,
  input  instr_t q2_instr_i,
  input  logic   q0_illegal_i,
  input  logic   q1_illegal_i,
  input  logic   q2_illegal_i,
  output logic   valid_o,
  output instr_t instr_o,
  output logic   illegal_o,
  output logic   is_compressed_o
);

  quadrant_e quad;
  instr_t    sel_instr;
  logic      sel_illegal;
  logic      sel_compressed;

  assign quad = quadrant_e'(instr_i[1:0]);

  // ----------------------------------------
  // quadrant select
  // ----------------------------------------
  always_comb begin
    sel_instr      = instr_i;
    sel_illegal    = 1'b0;
    sel_compressed = 1'b1;
    unique case (quad)
      quad_0: begin
        sel_instr   = q0_instr_i;
        sel_illegal = q0_illegal_i;
      end
      quad_1: begin
        sel_instr   = q1_instr_i;
        sel_illegal = q1_illegal_i;
      end
      quad_2: begin
        sel_instr   = q2_instr_i;
        sel_illegal = q2_illegal_i;
      end
      quad_full: sel_compressed = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o         <= 1'b0;
      instr_o         <= '0;
      illegal_o       <= 1'b0;
      is_compressed_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        // illegal encodings hand back the original word
        instr_o         <= sel_illegal ? instr_i : sel_instr;
        illegal_o       <= sel_illegal;
        is_compressed_o <= sel_compressed;
      end
    end
  end

  // ----------------------------------------
  // assertions
  // ----------------------------------------
  a_reset_clears_valid: assert property (@(posedge clk_i) rst_i |=> !valid_o);

  a_valid_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    !rst_i |=> (valid_o == $past(valid_i)));

  // every expander result must be a full-width word
  a_legal_is_full_width: assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_o && is_compressed_o && !illegal_o) |-> (instr_o[1:0] == 2'b11));

endmodule

// File: rvc_decoder.sv
`timescale 1ns/1ps

module rvc_decoder import rvc_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   valid_i,
  input  instr_t instr_i,
  output logic   valid_o,
  output logic   illegal_o,
  output logic   is_compressed_o,
  output instr_t instr_o
);

  half_t  half;
  instr_t q0_instr;
  instr_t q1_instr;
  instr_t q2_instr;
  logic   q0_illegal;
  logic   q1_illegal;
  logic   q2_illegal;

  // all three expanders see the same half, the register picks one
  assign half = instr_i[15:0];

  rvc_expand_q0 u_q0 (.half_i(half), .instr_o(q0_instr), .illegal_o(q0_illegal));
  rvc_expand_q1 u_q1 (.half_i(half), .instr_o(q1_instr), .illegal_o(q1_illegal));
  rvc_expand_q2 u_q2 (.half_i(half), .instr_o(q2_instr), .illegal_o(q2_illegal));

  rvc_decode_reg u_decode_reg (
    .clk_i(clk_i), .rst_i(rst_i), .valid_i(valid_i), .instr_i(instr_i),
    .q0_instr_i(q0_instr), .q1_instr_i(q1_instr), .q2_instr_i(q2_instr),
    .q0_illegal_i(q0_illegal), .q1_illegal_i(q1_illegal), .q2_illegal_i(q2_illegal),
    .valid_o(valid_o), .instr_o(instr_o), .illegal_o(illegal_o),
    .is_compressed_o(is_compressed_o)
  );

endmodule

// File: tb_rvc_decoder.sv
`timescale 1ns/1ps

module tb_rvc_decoder import rvc_pkg::*; ();

  localparam int reset_cycles = 3;
  // 4 + 18 + 49 + 26 + 25 single strobes and a burst of 8
  localparam int num_strobes  = 130;
  localparam int cycle_limit  = 2 * (num_strobes + reset_cycles);

  logic   clk_i;
  logic   rst_i;
  logic   valid_i;
  instr_t instr_i;
  logic   valid_o;
  logic   illegal_o;
  logic   is_compressed_o;
  instr_t instr_o;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [15:0] lfsr;

  rvc_decoder UUT (
    .clk_i(clk_i), .rst_i(rst_i), .valid_i(valid_i), .instr_i(instr_i),
    .valid_o(valid_o), .illegal_o(illegal_o), .is_compressed_o(is_compressed_o),
    .instr_o(instr_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // stimulus and reference helpers
  // ----------------------------------------
  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [4:0] nonzero_reg();
    logic [31:0] r;
    r = rand_bits(5);
    return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
  endfunction

  // rv32 formats where R-type takes funct7 from imm[11:5]
  function automatic instr_t encode(opcode_e opc, logic [2:0] f3, logic [4:0] rd,
                                    logic [4:0] rs1, logic [4:0] rs2, logic [31:0] imm);
    case (opc)
      opc_op:     return {imm[11:5], rs2, rs1, f3, rd, opc};
      opc_store:  return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
      opc_branch: return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
      opc_lui:    return {imm[31:12], rd, opc};
      opc_jal:    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
      default:    return {imm[11:0], rs1, f3, rd, opc};
    endcase
  endfunction

  task automatic check_instr(string name, instr_t exp, instr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_out(string name, instr_t word, instr_t exp, logic ill);
    check_flag({name, " valid"}, 1'b1, valid_o);
    check_instr(name, exp, instr_o);
    check_flag({name, " illegal"}, ill, illegal_o);
    check_flag({name, " compressed"}, word[1:0] != 2'b11, is_compressed_o);
  endtask

  // one strobe and its result one cycle later
  task automatic apply(string name, instr_t word, instr_t exp, logic ill);
    @(negedge clk_i);
    valid_i = 1'b1;
    instr_i = word;
    @(negedge clk_i);
    valid_i = 1'b0;
    check_out(name, word, exp, ill);
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic test_reset_passthrough();
    logic [31:0] r;
    instr_t      w;
    check_flag("reset valid", 1'b0, valid_o);
    check_instr("reset instr", 32'd0, instr_o);
    check_flag("reset illegal", 1'b0, illegal_o);
    check_flag("reset compressed", 1'b0, is_compressed_o);
    for (int n = 0; n < 4; n++) begin
      r = rand_bits(30);
      w = {r[29:0], 2'b11};
      apply("pass-through", w, w, 1'b0);
    end
  endtask

  task automatic test_quadrant0();
    logic [2:0]  slots[5] = '{3'd1, 3'd3, 3'd4, 3'd5, 3'd7};
    logic [31:0] u;
    logic [31:0] ra;
    logic [31:0] rb;
    instr_t      w;
    for (int n = 0; n < 4; n++) begin
      u  = rand_bits(8) << 2;
      if (u == 0) u = 32'd4;
      ra = rand_bits(3);
      rb = rand_bits(3);
      apply("c.addi4spn", {3'b000, u[5:4], u[9:6], u[2], u[3], ra[2:0], 2'b00},
            encode(opc_op_imm, 3'b000, {2'b01, ra[2:0]}, reg_sp, reg_zero, u), 1'b0);
      u = rand_bits(5) << 2;
      apply("c.lw", {3'b010, u[5:3], rb[2:0], u[2], u[6], ra[2:0], 2'b00},
            encode(opc_load, 3'b010, {2'b01, ra[2:0]}, {2'b01, rb[2:0]}, reg_zero, u), 1'b0);
      apply("c.sw", {3'b110, u[5:3], rb[2:0], u[2], u[6], ra[2:0], 2'b00},
            encode(opc_store, 3'b010, reg_zero, {2'b01, rb[2:0]}, {2'b01, ra[2:0]}, u), 1'b0);
    end
    w = {16'b0, 3'b000, 8'b0, ra[2:0], 2'b00};
    apply("c.addi4spn zero", w, w, 1'b1);
    // fp loads/stores and the zcb slot
    for (int s = 0; s < 5; s++) begin
      u = rand_bits(11);
      w = {16'b0, slots[s], u[10:0], 2'b00};
      apply("q0 reserved", w, w, 1'b1);
    end
  endtask

  task automatic test_q1_arith();
    string       alu_name[4] = '{"c.sub", "c.xor", "c.or", "c.and"};
    logic [2:0]  alu_f3[4]   = '{3'b000, 3'b100, 3'b110, 3'b111};
    logic [31:0] alu_f7[4]   = '{32'h400, 32'h0, 32'h0, 32'h0};
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] p;
    logic [31:0] q;
    logic [31:0] s;
    logic [31:0] imm;
    logic [31:0] n16;
    instr_t      w;
    for (int n = 0; n < 4; n++) begin
      a = rand_bits(6);
      if (a[5:0] == 6'd0) a = 32'd1;
      d = rand_bits(5);
      if (d[4:0] == 5'd0 || d[4:0] == 5'd2) d = d + 1;
      p = rand_bits(3);
      q = rand_bits(3);
      s = rand_bits(5);
      imm = {{26{a[5]}}, a[5:0]};
      n16 = {{22{a[5]}}, a[5:0], 4'b0};
      apply("c.addi", {3'b000, a[5], d[4:0], a[4:0], 2'b01},
            encode(opc_op_imm, 3'b000, d[4:0], d[4:0], reg_zero, imm), 1'b0);
      apply("c.li", {3'b010, a[5], d[4:0], a[4:0], 2'b01},
            encode(opc_op_imm, 3'b000, d[4:0], reg_zero, reg_zero, imm), 1'b0);
      apply("c.lui", {3'b011, a[5], d[4:0], a[4:0], 2'b01},
            encode(opc_lui, 3'b000, d[4:0], reg_zero, reg_zero, imm << 12), 1'b0);
      apply("c.addi16sp", {3'b011, n16[9], reg_sp, n16[4], n16[6], n16[8:7], n16[5], 2'b01},
            encode(opc_op_imm, 3'b000, reg_sp, reg_sp, reg_zero, n16), 1'b0);
      apply("c.srli", {3'b100, 1'b0, 2'b00, p[2:0], s[4:0], 2'b01},
            encode(opc_op_imm, 3'b101, {2'b01, p[2:0]}, {2'b01, p[2:0]}, reg_zero, s), 1'b0);
      apply("c.srai", {3'b100, 1'b0, 2'b01, p[2:0], s[4:0], 2'b01},
            encode(opc_op_imm, 3'b101, {2'b01, p[2:0]}, {2'b01, p[2:0]}, reg_zero,
                   s | 32'h400), 1'b0);
      apply("c.andi", {3'b100, a[5], 2'b10, p[2:0], a[4:0], 2'b01},
            encode(opc_op_imm, 3'b111, {2'b01, p[2:0]}, {2'b01, p[2:0]}, reg_zero, imm), 1'b0);
      for (int k = 0; k < 4; k++) begin
        apply(alu_name[k], {3'b100, 1'b0, 2'b11, p[2:0], k[1:0], q[2:0], 2'b01},
              encode(opc_op, alu_f3[k], {2'b01, p[2:0]}, {2'b01, p[2:0]}, {2'b01, q[2:0]},
                     alu_f7[k]), 1'b0);
      end
    end
    w = {16'b0, 3'b011, 1'b0, d[4:0], 5'b0, 2'b01};
    apply("c.lui zero", w, w, 1'b1);
    // subw, addw and the zcb group
    for (int k = 0; k < 4; k++) begin
      w = {16'b0, 3'b100, 1'b1, 2'b11, p[2:0], k[1:0], q[2:0], 2'b01};
      apply("q1 alu reserved", w, w, 1'b1);
    end
  endtask

  task automatic test_control();
    logic [31:0] o;
    logic [31:0] b;
    logic [31:0] p;
    logic [4:0]  d;
    for (int n = 0; n < 4; n++) begin
      o = rand_bits(11) << 1;
      o = {{20{o[11]}}, o[11:0]};
      b = rand_bits(8) << 1;
      b = {{23{b[8]}}, b[8:0]};
      p = rand_bits(3);
      d = nonzero_reg();
      apply("c.j", {3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01},
            encode(opc_jal, 3'b000, reg_zero, reg_zero, reg_zero, o), 1'b0);
      apply("c.jal", {3'b001, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01},
            encode(opc_jal, 3'b000, reg_ra, reg_zero, reg_zero, o), 1'b0);
      apply("c.beqz", {3'b110, b[8], b[4:3], p[2:0], b[7:6], b[2:1], b[5], 2'b01},
            encode(opc_branch, 3'b000, reg_zero, {2'b01, p[2:0]}, reg_zero, b), 1'b0);
      apply("c.bnez", {3'b111, b[8], b[4:3], p[2:0], b[7:6], b[2:1], b[5], 2'b01},
            encode(opc_branch, 3'b001, reg_zero, {2'b01, p[2:0]}, reg_zero, b), 1'b0);
      apply("c.jr", {3'b100, 1'b0, d, 5'b0, 2'b10},
            encode(opc_jalr, 3'b000, reg_zero, d, reg_zero, 32'd0), 1'b0);
      apply("c.jalr", {3'b100, 1'b1, d, 5'b0, 2'b10},
            encode(opc_jalr, 3'b000, reg_ra, d, reg_zero, 32'd0), 1'b0);
    end
    apply("c.ebreak", 32'h9002, encode(opc_system, 3'b000, reg_zero, reg_zero, reg_zero, 32'd1),
          1'b0);
    apply("c.jr zero", 32'h8002, 32'h8002, 1'b1);
  endtask

  task automatic test_quadrant2();
    logic [2:0]  slots[4] = '{3'd1, 3'd3, 3'd5, 3'd7};
    logic [31:0] u;
    logic [31:0] s;
    logic [4:0]  d;
    logic [4:0]  e;
    instr_t      w;
    for (int n = 0; n < 4; n++) begin
      d = nonzero_reg();
      e = nonzero_reg();
      s = rand_bits(5);
      u = rand_bits(6) << 2;
      apply("c.slli", {3'b000, 1'b0, d, s[4:0], 2'b10},
            encode(opc_op_imm, 3'b001, d, d, reg_zero, s), 1'b0);
      apply("c.lwsp", {3'b010, u[5], d, u[4:2], u[7:6], 2'b10},
            encode(opc_load, 3'b010, d, reg_sp, reg_zero, u), 1'b0);
      apply("c.swsp", {3'b110, u[5:2], u[7:6], e, 2'b10},
            encode(opc_store, 3'b010, reg_zero, reg_sp, e, u), 1'b0);
      apply("c.mv", {3'b100, 1'b0, d, e, 2'b10},
            encode(opc_op, 3'b000, d, reg_zero, e, 32'd0), 1'b0);
      apply("c.add", {3'b100, 1'b1, d, e, 2'b10},
            encode(opc_op, 3'b000, d, d, e, 32'd0), 1'b0);
    end
    w = {16'b0, 3'b010, u[5], 5'b0, u[4:2], u[7:6], 2'b10};
    apply("c.lwsp zero", w, w, 1'b1);
    for (int k = 0; k < 4; k++) begin
      u = rand_bits(11);
      w = {16'b0, slots[k], u[10:0], 2'b10};
      apply("q2 fp reserved", w, w, 1'b1);
    end
  endtask

  // c.addi and full-width words alternate at one strobe per cycle
  task automatic test_burst();
    instr_t      words[8];
    instr_t      exps[8];
    logic [31:0] a;
    logic [31:0] d;
    for (int i = 0; i < 8; i++) begin
      a = rand_bits(6);
      d = rand_bits(5);
      if (i % 2 == 0) begin
        words[i] = {3'b000, a[5], d[4:0], a[4:0], 2'b01};
        exps[i]  = encode(opc_op_imm, 3'b000, d[4:0], d[4:0], reg_zero, {{26{a[5]}}, a[5:0]});
      end else begin
        a        = rand_bits(30);
        words[i] = {a[29:0], 2'b11};
        exps[i]  = words[i];
      end
    end
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_i);
      if (i > 0) check_out("burst", words[i-1], exps[i-1], 1'b0);
      valid_i = 1'b1;
      instr_i = words[i];
    end
    @(negedge clk_i);
    valid_i = 1'b0;
    // a new word without a strobe must leave the outputs alone
    instr_i = words[0];
    check_out("burst", words[7], exps[7], 1'b0);
    @(negedge clk_i);
    check_flag("burst end valid", 1'b0, valid_o);
    check_instr("burst hold", exps[7], instr_o);
    check_flag("burst hold compressed", 1'b0, is_compressed_o);
  endtask

  initial begin
    clk_i   = 1'b0;
    rst_i   = 1'b1;
    // a strobe held through reset must not reach the outputs
    valid_i = 1'b1;
    instr_i = 32'h0000_4505;
    lfsr    = 16'd51;
    repeat (reset_cycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_i   = 1'b0;
    valid_i = 1'b0;
    test_reset_passthrough();
    test_quadrant0();
    test_q1_arith();
    test_control();
    test_quadrant2();
    test_burst();
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
rvc_pkg.sv
rvc_expand_q0.sv
rvc_expand_q1.sv
rvc_expand_q2.sv
rvc_decode_reg.sv
rvc_decoder.sv
tb_rvc_decoder.sv

// File: Bender.yml
package:
  name: rvc_decoder

sources:
  - rvc_pkg.sv
  - rvc_expand_q0.sv
  - rvc_expand_q1.sv
  - rvc_expand_q2.sv
  - rvc_decode_reg.sv
  - rvc_decoder.sv
  - target: test
    files:
      - tb_rvc_decoder.sv
